/* source/cpu_pkg.sv */
package cpu_pkg;

	// ----------------------------------------
	// Basic widths
	// ----------------------------------------
	// Data word, instruction word and byte address
	typedef logic [15:0] word_t;
	// Register number, r0 reads as zero
	typedef logic [3:0]  reg_idx_t;
	// Flags packed as {Z, V, N}
	typedef logic [2:0]  flag_t;

	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// ----------------------------------------
	// Opcodes and forwarding sources
	// ----------------------------------------
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRL = 4'h5,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_BR  = 4'hC,
		OP_HLT = 4'hF
	} opcode_t;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_MEM  = 2'b01,
		FWD_WB   = 2'b10
	} fwd_sel_t;

	// Instruction fields
	localparam int OP_HI   = 15;
	localparam int OP_LO   = 12;
	localparam int RD_HI   = 11;
	localparam int RD_LO   = 8;
	localparam int RS_HI   = 7;
	localparam int RS_LO   = 4;
	localparam int RT_HI   = 3;
	localparam int RT_LO   = 0;
	localparam int IMM8_HI = 7;
	localparam int IMM4_HI = 3;
	localparam int BOFF_HI = 8;
	localparam int IMM_LO  = 0;
	localparam int CC_HI   = 11;
	localparam int CC_LO   = 9;

	// Branch condition codes
	localparam logic [2:0] CC_NE     = 3'b000;
	localparam logic [2:0] CC_EQ     = 3'b001;
	localparam logic [2:0] CC_GT     = 3'b010;
	localparam logic [2:0] CC_LT     = 3'b011;
	localparam logic [2:0] CC_ALWAYS = 3'b111;

endpackage

/* source/decode_ctrl.sv */
`timescale 1ns/100ps

module decode_ctrl import cpu_pkg::*; (
	input  word_t    instr,
	output logic     reg_write,
	output logic     mem_to_reg,
	output logic     mem_write,
	output logic     is_load,
	output logic     is_halt,
	output reg_idx_t read_sel_1,
	output reg_idx_t read_sel_2,
	output reg_idx_t write_sel
);

	reg_idx_t rd, rs, rt;

	// Register fields
	assign rd = instr[RD_HI:RD_LO];
	assign rs = instr[RS_HI:RS_LO];
	assign rt = instr[RT_HI:RT_LO];

	// Destination is always the rd field
	assign write_sel = rd;

	always_comb begin
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		mem_write  = 1'b0;
		is_load    = 1'b0;
		is_halt    = 1'b0;
		// Unused ports point at r0 so no false stall
		read_sel_1 = '0;
		read_sel_2 = '0;
		case (opcode_t'(instr[OP_HI:OP_LO]))
			OP_ADD, OP_SUB, OP_XOR, OP_AND: begin
				reg_write  = 1'b1;
				read_sel_1 = rs;
				read_sel_2 = rt;
			end
			OP_SLL, OP_SRL: begin
				reg_write  = 1'b1;
				read_sel_1 = rs;
			end
			// Base register on port 2
			OP_LW: begin
				reg_write  = 1'b1;
				mem_to_reg = 1'b1;
				is_load    = 1'b1;
				read_sel_2 = rs;
			end
			// Store data on port 1, base on port 2
			OP_SW: begin
				mem_write  = 1'b1;
				read_sel_1 = rd;
				read_sel_2 = rs;
			end
			// Old rd value is merged with the byte
			OP_LHB, OP_LLB: begin
				reg_write  = 1'b1;
				read_sel_1 = rd;
			end
			OP_HLT: begin
				is_halt = 1'b1;
			end
			// br and illegal codes write nothing
			default: ;
		endcase
	end

endmodule

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t read_sel_1,
	input  reg_idx_t read_sel_2,
	input  reg_idx_t write_sel,
	input  logic     write_en,
	input  word_t    write_data,
	output word_t    read_data_1,
	output word_t    read_data_2
);

	word_t regs [16];

	// r0 is never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_sel != '0) begin
			regs[write_sel] <= write_data;
		end
	end

	// Reads see a same-cycle WB write
	assign read_data_1 = (read_sel_1 == '0) ? '0 :
		(write_en && write_sel == read_sel_1) ? write_data : regs[read_sel_1];
	assign read_data_2 = (read_sel_2 == '0) ? '0 :
		(write_en && write_sel == read_sel_2) ? write_data : regs[read_sel_2];

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
	input  word_t instr,
	input  word_t op_a,
	input  word_t op_b,
	output word_t result,
	output flag_t flag_out,
	output flag_t flag_we
);

	word_t      sum, diff;
	logic [3:0] shamt;
	logic [7:0] imm8;

	assign sum   = op_a + op_b;
	assign diff  = op_a - op_b;
	assign shamt = instr[IMM4_HI:IMM_LO];
	assign imm8  = instr[IMM8_HI:IMM_LO];

	always_comb begin
		result   = '0;
		flag_we  = '0;
		flag_out = '0;
		case (opcode_t'(instr[OP_HI:OP_LO]))
			// Signed overflow when operand signs agree and the sum sign differs
			OP_ADD: begin
				result           = sum;
				flag_we          = '1;
				flag_out[FLAG_V] = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
			end
			OP_SUB: begin
				result           = diff;
				flag_we          = '1;
				flag_out[FLAG_V] = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);
			end
			// Logic and shifts, Z only
			OP_XOR: begin
				result          = op_a ^ op_b;
				flag_we[FLAG_Z] = 1'b1;
			end
			OP_AND: begin
				result          = op_a & op_b;
				flag_we[FLAG_Z] = 1'b1;
			end
			OP_SLL: begin
				result          = op_a << shamt;
				flag_we[FLAG_Z] = 1'b1;
			end
			OP_SRL: begin
				result          = op_a >> shamt;
				flag_we[FLAG_Z] = 1'b1;
			end
			// Byte loads keep the other half of rd
			OP_LHB: result = {imm8, op_a[7:0]};
			OP_LLB: result = {op_a[15:8], imm8};
			default: ;
		endcase
		flag_out[FLAG_Z] = (result == '0);
		flag_out[FLAG_N] = result[15];
	end

endmodule

/* source/branch_ctrl.sv */
`timescale 1ns/100ps

module branch_ctrl import cpu_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  flush,
	input  word_t instr,
	input  word_t pc_plus_2,
	input  flag_t flag_in,
	input  flag_t flag_we,
	output logic  taken,
	output word_t target
);

	flag_t      flags;
	logic       cond_met;
	logic [2:0] cond;
	logic [8:0] offset;

	assign cond   = instr[CC_HI:CC_LO];
	assign offset = instr[BOFF_HI:IMM_LO];

	// Per-bit update, squashed work leaves flags alone
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (!flush) begin
			flags <= (flags & ~flag_we) | (flag_in & flag_we);
		end
	end

	// Condition on the registered flags
	always_comb begin
		case (cond)
			CC_NE:     cond_met = !flags[FLAG_Z];
			CC_EQ:     cond_met = flags[FLAG_Z];
			CC_GT:     cond_met = !flags[FLAG_Z] && !flags[FLAG_N];
			CC_LT:     cond_met = flags[FLAG_N];
			CC_ALWAYS: cond_met = 1'b1;
			default:   cond_met = 1'b0;
		endcase
	end

	assign taken  = (instr[OP_HI:OP_LO] == OP_BR) && cond_met;
	// Offset counts instructions
	assign target = pc_plus_2 + {{6{offset[8]}}, offset, 1'b0};

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t id_read_sel_1,
	input  reg_idx_t id_read_sel_2,
	input  reg_idx_t ex_write_sel,
	input  reg_idx_t mem_write_sel,
	input  reg_idx_t wb_write_sel,
	input  logic     ex_is_load,
	input  logic     mem_reg_write,
	input  logic     wb_reg_write,
	input  logic     id_is_halt,
	input  logic     wb_is_halt,
	input  logic     flush,
	output logic     stall,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output logic     halt_fetch,
	output logic     hlt
);

	typedef enum logic [1:0] {RUNNING, DRAINING, HALTED} halt_state_t;

	halt_state_t state, state_next;
	reg_idx_t    ex_read_sel_1, ex_read_sel_2;

	// Youngest writer wins, r0 never forwarded
	function automatic fwd_sel_t pick_fwd(input reg_idx_t sel, input logic mem_we,
		input reg_idx_t mem_sel, input logic wb_we, input reg_idx_t wb_sel);
		if (sel == '0) begin
			return FWD_NONE;
		end
		if (mem_we && mem_sel == sel) begin
			return FWD_MEM;
		end
		if (wb_we && wb_sel == sel) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	// Read selects follow the instruction into EX
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_read_sel_1 <= '0;
			ex_read_sel_2 <= '0;
		end else begin
			ex_read_sel_1 <= id_read_sel_1;
			ex_read_sel_2 <= id_read_sel_2;
		end
	end

	assign fwd_a = pick_fwd(ex_read_sel_1, mem_reg_write, mem_write_sel,
		wb_reg_write, wb_write_sel);
	assign fwd_b = pick_fwd(ex_read_sel_2, mem_reg_write, mem_write_sel,
		wb_reg_write, wb_write_sel);

	// Load result not ready for the very next instruction
	assign stall = ex_is_load && (ex_write_sel != '0)
		&& (ex_write_sel == id_read_sel_1 || ex_write_sel == id_read_sel_2);

	// ----------------------------------------
	// Halt FSM
	// ----------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			// Taken branch in EX squashes the HLT, keep running
			RUNNING:  state_next = (id_is_halt && !flush) ? DRAINING : RUNNING;
			DRAINING: state_next = wb_is_halt ? HALTED : DRAINING;
			default:  state_next = HALTED;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= RUNNING;
		end else begin
			state <= state_next;
		end
	end

	assign halt_fetch = (state != RUNNING);
	assign hlt        = (state == HALTED) || wb_is_halt;

	// Once halted the core stays halted
	a_hlt_sticky: assert property (@(posedge clk) disable iff (!arst_n) hlt |=> hlt);

endmodule

/* source/cpu.sv */
`timescale 1ns/100ps

module cpu import cpu_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  word_t imem_data,
	input  word_t dmem_rdata,
	output word_t imem_addr,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	output logic  dmem_re,
	output logic  hlt,
	output word_t pc_out
);

	// Hazard and branch control
	logic     stall, flush, halt_fetch, halt_hold;
	fwd_sel_t fwd_a, fwd_b;
	word_t    branch_target;

	// IF
	word_t pc, pc_plus_2;

	// ID
	logic     id_valid, id_go, id_is_halt;
	word_t    id_instr, id_pc_plus_2, id_data_1, id_data_2;
	logic     dec_reg_write, dec_mem_to_reg, dec_mem_write, dec_is_load, dec_is_halt;
	reg_idx_t dec_read_sel_1, dec_read_sel_2, dec_write_sel;

	// EX
	logic     ex_valid, ex_reg_write, ex_mem_to_reg, ex_mem_write, ex_is_load, ex_is_halt;
	reg_idx_t ex_write_sel;
	word_t    ex_instr, ex_pc_plus_2, ex_data_1, ex_data_2;
	word_t    ex_op_a, ex_op_b, ex_result, ex_mem_addr;
	flag_t    alu_flag_out, alu_flag_we, ex_flag_we;

	// MEM
	logic     mem_reg_write, mem_mem_to_reg, mem_mem_write, mem_is_load, mem_is_halt;
	reg_idx_t mem_write_sel;
	word_t    mem_result, mem_addr, mem_store_data, mem_wb_data;

	// WB
	logic     wb_reg_write, wb_is_halt;
	reg_idx_t wb_write_sel;
	word_t    wb_data;

	// ----------------------------------------
	// IF stage
	// ----------------------------------------
	assign pc_plus_2  = pc + 16'd2;
	assign imem_addr  = pc;
	assign pc_out     = pc;
	assign id_is_halt = id_valid & dec_is_halt;
	// Fetch stops as soon as HLT sits in ID
	assign halt_hold  = halt_fetch | id_is_halt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (flush) begin
			pc <= branch_target;
		end else if (!stall && !halt_hold) begin
			pc <= pc_plus_2;
		end
	end

	// IF/ID, flush beats stall, stall beats halt bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid <= 1'b0;
			id_instr <= '0;
		end else if (flush || (halt_hold && !stall)) begin
			id_valid <= 1'b0;
			id_instr <= '0;
		end else if (!stall) begin
			id_valid <= 1'b1;
			id_instr <= imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc_plus_2 <= pc_plus_2;
		end
	end

	// ----------------------------------------
	// ID stage
	// ----------------------------------------
	decode_ctrl u_decode_ctrl (
		.instr      (id_instr),
		.reg_write  (dec_reg_write),
		.mem_to_reg (dec_mem_to_reg),
		.mem_write  (dec_mem_write),
		.is_load    (dec_is_load),
		.is_halt    (dec_is_halt),
		.read_sel_1 (dec_read_sel_1),
		.read_sel_2 (dec_read_sel_2),
		.write_sel  (dec_write_sel)
	);

	register_file u_register_file (
		.clk         (clk),
		.arst_n      (arst_n),
		.read_sel_1  (dec_read_sel_1),
		.read_sel_2  (dec_read_sel_2),
		.write_sel   (wb_write_sel),
		.write_en    (wb_reg_write),
		.write_data  (wb_data),
		.read_data_1 (id_data_1),
		.read_data_2 (id_data_2)
	);

	// Instruction moves on to EX, otherwise a bubble goes in
	assign id_go = id_valid & ~flush & ~stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid      <= 1'b0;
			ex_reg_write  <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_is_load    <= 1'b0;
			ex_is_halt    <= 1'b0;
			ex_instr      <= '0;
		end else begin
			ex_valid      <= id_go;
			ex_reg_write  <= id_go & dec_reg_write;
			ex_mem_to_reg <= id_go & dec_mem_to_reg;
			ex_mem_write  <= id_go & dec_mem_write;
			ex_is_load    <= id_go & dec_is_load;
			ex_is_halt    <= id_go & dec_is_halt;
			ex_instr      <= id_go ? id_instr : '0;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc_plus_2 <= id_pc_plus_2;
		ex_data_1    <= id_data_1;
		ex_data_2    <= id_data_2;
		ex_write_sel <= dec_write_sel;
	end

	// ----------------------------------------
	// EX stage
	// ----------------------------------------
	// Operand muxes, MEM result is the younger one
	always_comb begin
		case (fwd_a)
			FWD_MEM: ex_op_a = mem_wb_data;
			FWD_WB:  ex_op_a = wb_data;
			default: ex_op_a = ex_data_1;
		endcase
		case (fwd_b)
			FWD_MEM: ex_op_b = mem_wb_data;
			FWD_WB:  ex_op_b = wb_data;
			default: ex_op_b = ex_data_2;
		endcase
	end

	// Base plus word offset for LW and SW
	assign ex_mem_addr = ex_op_b
		+ {{11{ex_instr[IMM4_HI]}}, ex_instr[IMM4_HI:IMM_LO], 1'b0};
	// Bubbles never touch the flags
	assign ex_flag_we = ex_valid ? alu_flag_we : '0;

	alu u_alu (
		.instr    (ex_instr),
		.op_a     (ex_op_a),
		.op_b     (ex_op_b),
		.result   (ex_result),
		.flag_out (alu_flag_out),
		.flag_we  (alu_flag_we)
	);

	branch_ctrl u_branch_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.instr     (ex_instr),
		.pc_plus_2 (ex_pc_plus_2),
		.flag_in   (alu_flag_out),
		.flag_we   (ex_flag_we),
		.taken     (flush),
		.target    (branch_target)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_reg_write  <= 1'b0;
			mem_mem_to_reg <= 1'b0;
			mem_mem_write  <= 1'b0;
			mem_is_load    <= 1'b0;
			mem_is_halt    <= 1'b0;
		end else begin
			mem_reg_write  <= ex_reg_write;
			mem_mem_to_reg <= ex_mem_to_reg;
			mem_mem_write  <= ex_mem_write;
			mem_is_load    <= ex_is_load;
			mem_is_halt    <= ex_is_halt;
		end
	end

	always_ff @(posedge clk) begin
		mem_write_sel  <= ex_write_sel;
		mem_result     <= ex_result;
		mem_addr       <= ex_mem_addr;
		mem_store_data <= ex_op_a;
	end

	// ----------------------------------------
	// MEM and WB stages
	// ----------------------------------------
	assign dmem_addr   = mem_addr;
	assign dmem_wdata  = mem_store_data;
	assign dmem_we     = mem_mem_write;
	assign dmem_re     = mem_is_load;
	assign mem_wb_data = mem_mem_to_reg ? dmem_rdata : mem_result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_reg_write <= 1'b0;
			wb_is_halt   <= 1'b0;
		end else begin
			wb_reg_write <= mem_reg_write;
			wb_is_halt   <= mem_is_halt;
		end
	end

	always_ff @(posedge clk) begin
		wb_write_sel <= mem_write_sel;
		wb_data      <= mem_wb_data;
	end

	hazard_unit u_hazard_unit (
		.clk           (clk),
		.arst_n        (arst_n),
		.id_read_sel_1 (dec_read_sel_1),
		.id_read_sel_2 (dec_read_sel_2),
		.ex_write_sel  (ex_write_sel),
		.mem_write_sel (mem_write_sel),
		.wb_write_sel  (wb_write_sel),
		.ex_is_load    (ex_is_load),
		.mem_reg_write (mem_reg_write),
		.wb_reg_write  (wb_reg_write),
		.id_is_halt    (id_is_halt),
		.wb_is_halt    (wb_is_halt),
		.flush         (flush),
		.stall         (stall),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.halt_fetch    (halt_fetch),
		.hlt           (hlt)
	);

	// A MEM-stage instruction is either a load or a store, never both
	a_dmem_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(dmem_we && dmem_re));

endmodule

/* dv/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;

	localparam int PROG_LEN    = 59;
	localparam int STORE_LEN   = 16;
	localparam int LOAD_LEN    = 2;
	localparam int HLT_TIMEOUT = 500;
	localparam int HOLD_CYCLES = 20;
	// HLT sits at 0x0070, the PC parks on the word after it
	localparam logic [15:0] HALT_PC = 16'h0072;

	logic        clk;
	logic        arst_n;
	logic [15:0] imem_data;
	logic [15:0] dmem_rdata;
	logic [15:0] imem_addr;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic [15:0] pc_out;
	logic        dmem_we;
	logic        dmem_re;
	logic        hlt;

	// Memory models, word index from address bits 6:1
	logic [15:0] imem [64];
	logic [15:0] dmem [64];
	// Copy of the random preload for expected load values
	logic [15:0] init_mem [64];

	int          seed;
	int          errors;
	int          store_count;
	int          load_count;

	// ----------------------------------------
	// Program table
	// ----------------------------------------
	logic [15:0] program_rom [PROG_LEN] = '{
		// Constants, r1 = 1234, r14 = 0020 store base, r2 = 0FF0
		16'hB134, 16'hA112, 16'hBE20, 16'hB2F0, 16'hA20F,
		// add, sub, xor, and, sll, srl chain at distance 1 and 2
		16'h0312, 16'h93E0, 16'h1431, 16'h2541, 16'h3653,
		16'h4763, 16'h5852,
		// Store r4..r8
		16'h94E1, 16'h95E2, 16'h96E3, 16'h97E4, 16'h98E5,
		// Write to r0 dropped, then store r0 and r0 + r1
		16'h0012, 16'h90E6, 16'h0901, 16'h99E7,
		// r13 = 0030, LW then dependent ADD, LW then SW of same reg
		16'hBD30, 16'h8A01, 16'h0BA1, 16'h9BD0, 16'h8C02,
		16'h9CD1,
		// NE taken over two stores
		16'h1F12, 16'hC002, 16'h91D2, 16'h91D3, 16'h9FD2,
		// EQ not taken
		16'h3F12, 16'hC201, 16'h9FD3,
		// EQ taken
		16'h2F11, 16'hC202, 16'h91D4, 16'h91D5, 16'h92D4,
		// GT not taken on a negative result
		16'h1F21, 16'hC401, 16'h9FD5,
		// LT taken
		16'h1F21, 16'hC602, 16'h91D6, 16'h91D7,
		// GT taken
		16'h0F12, 16'hC402, 16'h91D6, 16'h91D7, 16'h9FD6,
		// Always taken
		16'hCE02, 16'h91D7, 16'h91D7, 16'h93D7,
		// HLT, the two stores after it must never show up
		16'hF000, 16'h91E0, 16'h92E1
	};

	// Expected stores in order, byte address and data
	logic [15:0] exp_addr [STORE_LEN] = '{
		16'h0020, 16'h0022, 16'h0024, 16'h0026, 16'h0028, 16'h002A,
		16'h002C, 16'h002E, 16'h0030, 16'h0032, 16'h0034, 16'h0036,
		16'h0038, 16'h003A, 16'h003C, 16'h003E
	};
	// Entries 8 and 9 depend on the preload and are set at start
	logic [15:0] exp_data [STORE_LEN] = '{
		16'h2224, 16'h0FF0, 16'h1DC4, 16'h0004, 16'h0020, 16'h0771,
		16'h0000, 16'h1234, 16'h0000, 16'h0000, 16'h0244, 16'h0230,
		16'h0FF0, 16'hFDBC, 16'h2224, 16'h2224
	};

	// Expected loads in order, r0 base plus word offsets 1 and 2
	logic [15:0] exp_load_addr [LOAD_LEN] = '{
		16'h0002, 16'h0004
	};

	cpu u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.imem_data  (imem_data),
		.dmem_rdata (dmem_rdata),
		.imem_addr  (imem_addr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.hlt        (hlt),
		.pc_out     (pc_out)
	);

	// Both memories answer in the same cycle
	assign imem_data  = imem[imem_addr[6:1]];
	assign dmem_rdata = dmem[dmem_addr[6:1]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Compare one committed store against the table
	task automatic record_store(input logic [15:0] addr, input logic [15:0] data);
		if (hlt) begin
			$display("Store to address %h seen after hlt", addr);
			errors++;
		end else if (store_count >= STORE_LEN) begin
			$display("Unexpected extra store to address %h", addr);
			errors++;
		end else begin
			if (addr != exp_addr[store_count]) begin
				$display("Error: dmem_addr store %0d is %h, expected %h",
					store_count, addr, exp_addr[store_count]);
				errors++;
			end
			if (data != exp_data[store_count]) begin
				$display("Error: dmem_wdata store %0d is %h, expected %h",
					store_count, data, exp_data[store_count]);
				errors++;
			end
		end
		store_count++;
	endtask

	// Compare one load read against the table
	task automatic record_load(input logic [15:0] addr);
		if (load_count >= LOAD_LEN) begin
			$display("Unexpected extra load from address %h", addr);
			errors++;
		end else if (addr != exp_load_addr[load_count]) begin
			$display("Error: dmem_addr load %0d is %h, expected %h",
				load_count, addr, exp_load_addr[load_count]);
			errors++;
		end
		load_count++;
	endtask

	// ----------------------------------------
	// Store and load monitor
	// ----------------------------------------
	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[6:1]] <= dmem_wdata;
			record_store(dmem_addr, dmem_wdata);
		end
		if (dmem_re) begin
			record_load(dmem_addr);
		end
	end

	initial begin
		int          rnd;
		int          cycles;

		seed        = 32'hdb75_cfb5;
		errors      = 0;
		store_count = 0;
		load_count  = 0;
		arst_n      = 1'b0;

		// Random data preload, HLT-coded fill beyond the program
		for (int i = 0; i < 64; i++) begin
			rnd         = $random(seed);
			init_mem[i] = rnd[15:0];
			dmem[i]     = rnd[15:0];
			if (i < PROG_LEN) begin
				imem[i] = program_rom[i];
			end else begin
				imem[i] = 16'hF000 | 16'(i);
			end
		end
		// LW from word 1 plus r1, LW from word 2 stored as is
		exp_data[8] = init_mem[1] + 16'h1234;
		exp_data[9] = init_mem[2];

		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		// Wait for halt
		cycles = 0;
		while (!hlt && cycles < HLT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end

		if (!hlt) begin
			$display("hlt never asserted within %0d cycles", HLT_TIMEOUT);
			errors++;
		end else begin
			// Core must stay parked
			repeat (HOLD_CYCLES) begin
				@(negedge clk);
				if (!hlt) begin
					$display("hlt fell without a reset");
					errors++;
				end
				if (pc_out != HALT_PC) begin
					$display("Error: pc_out is %h, expected %h", pc_out, HALT_PC);
					errors++;
				end
				if (imem_addr != HALT_PC) begin
					$display("Error: imem_addr is %h, expected %h", imem_addr, HALT_PC);
					errors++;
				end
			end
			if (store_count != STORE_LEN) begin
				$display("Wrong number of stores, %0d seen and %0d expected",
					store_count, STORE_LEN);
				errors++;
			end
			if (load_count != LOAD_LEN) begin
				$display("Wrong number of loads, %0d seen and %0d expected",
					load_count, LOAD_LEN);
				errors++;
			end
		end

		$display("Stores seen %0d of %0d, loads seen %0d of %0d, errors %0d",
			store_count, STORE_LEN, load_count, LOAD_LEN, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* cpu.f */
source/cpu_pkg.sv
source/decode_ctrl.sv
source/register_file.sv
source/alu.sv
source/branch_ctrl.sv
source/hazard_unit.sv
source/cpu.sv
dv/cpu_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
		-f cpu.f -Mdir obj_dir -o cpu_sim

run: compile
	./obj_dir/cpu_sim > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
